// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    //////////////////////////////
    // address and data geometry
    //////////////////////////////

    localparam int addr_width   = 32;
    localparam int data_width   = 32;
    localparam int index_width  = 4;
    localparam int offset_width = 2;
    // what is left of the address after index and byte offset
    localparam int tag_width    = addr_width - index_width - offset_width;
    localparam int strb_width   = data_width / 8;
    localparam int num_ways     = 2;
    localparam int num_sets     = 1 << index_width;

    typedef logic [addr_width-1:0]  addr_t;
    typedef logic [data_width-1:0]  word_t;
    typedef logic [tag_width-1:0]   tag_t;
    typedef logic [index_width-1:0] index_t;
    typedef logic [strb_width-1:0]  strobe_t;
    // one bit per way, one-hot where a single way is meant
    typedef logic [num_ways-1:0]    way_vec_t;

    //////////////////////////////
    // operations and control
    //////////////////////////////

    typedef enum logic [1:0] {
        op_load,
        op_store,
        op_invalidate
    } cache_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_refill_done,
        st_write,
        st_write_done
    } ctrl_state_t;

    // core request, 70 bits
    typedef struct packed {
        cache_op_t op;
        addr_t     addr;
        word_t     wdata;
        strobe_t   wstrb;
    } cache_req_t;

endpackage

// ==== source/dual_port_ram.sv ====
`timescale 1ns/100ps

// simple one-write one-read RAM, one entry per set
module dual_port_ram import dcache_pkg::*; #(
    parameter int width = data_width
) (
    input  logic             clk,
    input  logic             we,
    input  index_t           waddr,
    input  logic [width-1:0] din,
    input  index_t           raddr,
    output logic [width-1:0] dout
);

    logic [width-1:0] mem [num_sets];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
        // registered read, old data on a same-address write
        dout <= mem[raddr];
    end

endmodule

// ==== source/dcache_tagv.sv ====
`timescale 1ns/100ps

module dcache_tagv import dcache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    // tag RAM read address, one cycle ahead of the compare
    input  index_t   rd_index,
    // set of the buffered request, used for valid and writes
    input  index_t   buf_index,
    input  tag_t     cmp_tag,
    input  tag_t     wr_tag,
    input  way_vec_t we,
    input  logic     invalidate,
    output way_vec_t hit,
    output way_vec_t way_valid
);

    tag_t               tag_q   [num_ways];
    logic [num_sets-1:0] valid_q [num_ways];

    //////////////////////////////
    // per way tag RAM and valid bits
    //////////////////////////////

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        dual_port_ram #(
            .width(tag_width)
        ) i_tag_ram (
            .clk  (clk),
            .we   (we[w]),
            .waddr(buf_index),
            .din  (wr_tag),
            .raddr(rd_index),
            .dout (tag_q[w])
        );

        // fresh cache starts empty
        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q[w] <= '0;
            end else if (we[w]) begin
                // refill sets, invalidate clears
                valid_q[w][buf_index] <= ~invalidate;
            end
        end

        // valid looked up at the buffered set
        assign way_valid[w] = valid_q[w][buf_index];
        assign hit[w]       = way_valid[w] && (tag_q[w] == cmp_tag);
    end

    // a line lives in one way only, refill must never duplicate a tag
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(hit)
    );

endmodule

// ==== source/dcache_data.sv ====
`timescale 1ns/100ps

module dcache_data import dcache_pkg::*; (
    input  logic     clk,
    input  index_t   rd_index,
    input  index_t   wr_index,
    input  way_vec_t we,
    // full word write from memory
    input  logic     refill,
    input  word_t    refill_data,
    input  word_t    store_data,
    input  strobe_t  store_strb,
    input  way_vec_t sel,
    output word_t    rdata
);

    word_t ram_q  [num_ways];
    word_t merged [num_ways];
    word_t din    [num_ways];

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        // store hit, strobed bytes over the registered old word
        always_comb begin
            merged[w] = ram_q[w];
            for (int b = 0; b < strb_width; b++) begin
                if (store_strb[b]) begin
                    merged[w][8*b +: 8] = store_data[8*b +: 8];
                end
            end
        end

        assign din[w] = refill ? refill_data : merged[w];

        dual_port_ram #(
            .width(data_width)
        ) i_data_ram (
            .clk  (clk),
            .we   (we[w]),
            .waddr(wr_index),
            .din  (din[w]),
            .raddr(rd_index),
            .dout (ram_q[w])
        );
    end

    // one-hot way mux
    always_comb begin
        rdata = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (sel[w]) begin
                rdata = rdata | ram_q[w];
            end
        end
    end

    // controller writes a single way, hit way or victim
    a_we_onehot: assert property (
        @(posedge clk)
        $onehot0(we)
    );

endmodule

// ==== source/dcache_lru.sv ====
`timescale 1ns/100ps

module dcache_lru import dcache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  index_t   index,
    input  way_vec_t way_valid,
    input  logic     touch,
    input  way_vec_t touched_way,
    output way_vec_t victim
);

    // per set, 0 names way 0 as least recently used, 1 names way 1
    logic [num_sets-1:0] lru_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (touch) begin
            // the other way becomes the oldest
            lru_q[index] <= touched_way[0];
        end
    end

    // invalid way first, lowest index wins
    always_comb begin
        if (!way_valid[0]) begin
            victim = 2'b01;
        end else if (!way_valid[1]) begin
            victim = 2'b10;
        end else begin
            victim = lru_q[index] ? 2'b10 : 2'b01;
        end
    end

endmodule

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // core side
    input  logic       req_valid,
    input  cache_req_t req,
    output logic       busy,
    output logic       resp_valid,
    output word_t      rdata,
    // from tag, valid and LRU
    input  way_vec_t   hit,
    input  way_vec_t   way_valid,
    input  way_vec_t   victim,
    input  word_t      ram_rdata,
    // to tag and data stores
    output index_t     rd_index,
    output index_t     buf_index,
    output tag_t       buf_tag,
    output way_vec_t   tag_we,
    output logic       invalidate,
    output way_vec_t   data_we,
    output logic       refill,
    output word_t      refill_data,
    output word_t      store_data,
    output strobe_t    store_strb,
    output way_vec_t   data_sel,
    output logic       lru_touch,
    output way_vec_t   lru_way,
    // memory side
    output logic       mem_rd_req,
    output logic       mem_wr_req,
    output addr_t      mem_addr,
    output word_t      mem_wdata,
    output strobe_t    mem_wstrb,
    input  logic       mem_rd_valid,
    input  word_t      mem_rdata,
    input  logic       mem_wr_done
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    cache_req_t  buf_q;
    word_t       refill_q;

    //////////////////////////////
    // request buffer
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_q <= '0;
        end else if (state_q == st_idle && req_valid) begin
            buf_q <= req;
        end
        // memory word kept for the write and the response
        if (state_q == st_refill && mem_rd_valid) begin
            refill_q <= mem_rdata;
        end
    end

    assign buf_index = buf_q.addr[offset_width +: index_width];
    assign buf_tag   = buf_q.addr[addr_width-1 -: tag_width];

    // RAMs see the new index while idle so data is ready in lookup
    assign rd_index = (state_q == st_idle) ? req.addr[offset_width +: index_width] : buf_index;

    assign busy        = (state_q != st_idle);
    assign refill_data = refill_q;
    assign store_data  = buf_q.wdata;
    assign store_strb  = buf_q.wstrb;
    assign data_sel    = hit;
    // hit data straight from the RAM, miss data from the buffer
    assign rdata = (state_q == st_refill_done) ? refill_q : ram_rdata;

    // held by the buffer until memory answers
    assign mem_addr  = {buf_q.addr[addr_width-1:offset_width], {offset_width{1'b0}}};
    assign mem_wdata = buf_q.wdata;
    assign mem_wstrb = buf_q.wstrb;

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d    = state_q;
        resp_valid = 1'b0;
        mem_rd_req = 1'b0;
        mem_wr_req = 1'b0;
        tag_we     = '0;
        data_we    = '0;
        invalidate = 1'b0;
        refill     = 1'b0;
        lru_touch  = 1'b0;
        lru_way    = hit;
        case (state_q)
            st_idle: begin
                if (req_valid) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                case (buf_q.op)
                    op_load: begin
                        if (|hit) begin
                            resp_valid = 1'b1;
                            lru_touch  = 1'b1;
                            state_d    = st_idle;
                        end else begin
                            mem_rd_req = 1'b1;
                            state_d    = st_refill;
                        end
                    end
                    op_store: begin
                        // merge on hit, no allocate on miss
                        data_we    = hit;
                        lru_touch  = |hit;
                        mem_wr_req = 1'b1;
                        state_d    = st_write;
                    end
                    op_invalidate: begin
                        tag_we     = hit;
                        invalidate = 1'b1;
                        resp_valid = 1'b1;
                        state_d    = st_idle;
                    end
                    default: begin
                        // unused code, complete as a no-op
                        resp_valid = 1'b1;
                        state_d    = st_idle;
                    end
                endcase
            end
            st_refill: begin
                if (mem_rd_valid) begin
                    state_d = st_refill_done;
                end
            end
            st_refill_done: begin
                // tag, valid, data and LRU all land in the victim way
                tag_we     = victim;
                data_we    = victim;
                refill     = 1'b1;
                lru_touch  = 1'b1;
                lru_way    = victim;
                resp_valid = 1'b1;
                state_d    = st_idle;
            end
            st_write: begin
                if (mem_wr_done) begin
                    state_d = st_write_done;
                end
            end
            st_write_done: begin
                resp_valid = 1'b1;
                state_d    = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    //////////////////////////////
    // protocol checks
    //////////////////////////////

    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !req_valid
    );

    a_rd_valid_in_refill: assert property (
        @(posedge clk) disable iff (reset)
        mem_rd_valid |-> (state_q == st_refill)
    );

    // an empty way is always taken before a live line is evicted
    a_victim_prefers_invalid: assert property (
        @(posedge clk) disable iff (reset)
        (state_q == st_refill_done && !(&way_valid)) |-> !(|(victim & way_valid))
    );

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  cache_req_t req,
    output logic       busy,
    output logic       resp_valid,
    output word_t      rdata,
    output logic       mem_rd_req,
    output logic       mem_wr_req,
    output addr_t      mem_addr,
    output word_t      mem_wdata,
    output strobe_t    mem_wstrb,
    input  logic       mem_rd_valid,
    input  word_t      mem_rdata,
    input  logic       mem_wr_done
);

    way_vec_t hit;
    way_vec_t way_valid;
    way_vec_t victim;
    word_t    ram_rdata;
    index_t   rd_index;
    index_t   buf_index;
    tag_t     buf_tag;
    way_vec_t tag_we;
    logic     invalidate;
    way_vec_t data_we;
    logic     refill;
    word_t    refill_data;
    word_t    store_data;
    strobe_t  store_strb;
    way_vec_t data_sel;
    logic     lru_touch;
    way_vec_t lru_way;

    dcache_ctrl i_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .rdata       (rdata),
        .hit         (hit),
        .way_valid   (way_valid),
        .victim      (victim),
        .ram_rdata   (ram_rdata),
        .rd_index    (rd_index),
        .buf_index   (buf_index),
        .buf_tag     (buf_tag),
        .tag_we      (tag_we),
        .invalidate  (invalidate),
        .data_we     (data_we),
        .refill      (refill),
        .refill_data (refill_data),
        .store_data  (store_data),
        .store_strb  (store_strb),
        .data_sel    (data_sel),
        .lru_touch   (lru_touch),
        .lru_way     (lru_way),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_rd_valid(mem_rd_valid),
        .mem_rdata   (mem_rdata),
        .mem_wr_done (mem_wr_done)
    );

    // compare and write both use the buffered tag
    dcache_tagv i_tagv (
        .clk       (clk),
        .reset     (reset),
        .rd_index  (rd_index),
        .buf_index (buf_index),
        .cmp_tag   (buf_tag),
        .wr_tag    (buf_tag),
        .we        (tag_we),
        .invalidate(invalidate),
        .hit       (hit),
        .way_valid (way_valid)
    );

    dcache_data i_data (
        .clk        (clk),
        .rd_index   (rd_index),
        .wr_index   (buf_index),
        .we         (data_we),
        .refill     (refill),
        .refill_data(refill_data),
        .store_data (store_data),
        .store_strb (store_strb),
        .sel        (data_sel),
        .rdata      (ram_rdata)
    );

    dcache_lru i_lru (
        .clk        (clk),
        .reset      (reset),
        .index      (buf_index),
        .way_valid  (way_valid),
        .touch      (lru_touch),
        .touched_way(lru_way),
        .victim     (victim)
    );

endmodule

// ==== test/tb_dcache.sv ====
`timescale 1ns/100ps

module tb_dcache import dcache_pkg::*; ();

    localparam int num_requests = 400;
    // drive, lookup, worst memory latency, response, pulse check
    localparam int worst_cycles = 10;
    localparam int cycle_limit  = num_requests * worst_cycles + 100;

    logic       clk;
    logic       reset;
    logic       req_valid;
    cache_req_t req;
    logic       busy;
    logic       resp_valid;
    word_t      rdata;
    logic       mem_rd_req;
    logic       mem_wr_req;
    addr_t      mem_addr;
    word_t      mem_wdata;
    strobe_t    mem_wstrb;
    logic       mem_rd_valid;
    word_t      mem_rdata;
    logic       mem_wr_done;

    word_t rng_state   = 32'd67;
    int    cycle_count = 0;
    int    num_hits    = 0;
    int    num_misses  = 0;
    int    num_evicts  = 0;

    // sparse backing memory, word address as key
    word_t mem_words [addr_t];
    // reference cache, both ways of every set
    tag_t  model_tag   [num_sets][num_ways];
    logic  model_valid [num_sets][num_ways];
    word_t model_data  [num_sets][num_ways];
    // set means way 1 is least recently used
    logic  model_lru   [num_sets];

    dcache_top i_dcache_top (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .rdata       (rdata),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_rd_valid(mem_rd_valid),
        .mem_rdata   (mem_rdata),
        .mem_wr_done (mem_wr_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: requests not finished after %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // untouched words come from a pattern over the full address
    function automatic word_t mem_read(input addr_t a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return xorshift(a ^ 32'h6d2b_79f5);
    endfunction

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input strobe_t strb);
        word_t w;
        w = old_word;
        for (int b = 0; b < strb_width; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    // way holding the address, -1 when absent
    function automatic int find_way(input addr_t a);
        index_t idx;
        tag_t   tag;
        idx = a[offset_width +: index_width];
        tag = a[addr_width-1 -: tag_width];
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    // empty way first, else the least recently used one
    function automatic int choose_victim(input index_t idx);
        if (!model_valid[idx][0]) begin
            return 0;
        end
        if (!model_valid[idx][1]) begin
            return 1;
        end
        return model_lru[idx] ? 1 : 0;
    endfunction

    // three tags over sixteen sets, so sets overflow
    function automatic cache_req_t random_request();
        cache_req_t r;
        word_t      pick;
        tag_t       tag;
        index_t     idx;
        pick = next_rand() % 20;
        case (next_rand() % 3)
            0: tag = 26'h000_0001;
            1: tag = 26'h15a_5a5a;
            default: tag = 26'h3ff_fff0;
        endcase
        idx = index_t'(next_rand() % num_sets);
        if (pick < 10) begin
            r.op = op_load;
        end else if (pick < 16) begin
            r.op = op_store;
        end else begin
            r.op = op_invalidate;
        end
        r.addr  = {tag, idx, {offset_width{1'b0}}};
        r.wdata = next_rand();
        r.wstrb = strobe_t'(next_rand());
        if (r.wstrb == '0) begin
            r.wstrb = '1;
        end
        return r;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // one request, memory answers
    //////////////////////////////

    task automatic run_request(input cache_req_t r);
        index_t idx;
        tag_t   tag;
        int     way;
        int     cycles;
        int     resp_cycle;
        int     rd_reqs;
        int     wr_reqs;
        int     rd_delay;
        int     wr_delay;
        word_t  got;
        word_t  expected;
        idx        = r.addr[offset_width +: index_width];
        tag        = r.addr[addr_width-1 -: tag_width];
        way        = find_way(r.addr);
        expected   = mem_read(r.addr);
        cycles     = 0;
        resp_cycle = 0;
        rd_reqs    = 0;
        wr_reqs    = 0;
        rd_delay   = 0;
        wr_delay   = 0;
        while (busy) begin
            @(negedge clk);
        end
        req_valid = 1'b1;
        req       = r;
        @(negedge clk);
        req_valid = 1'b0;
        // one pass per falling edge, counted from the lookup cycle
        while (resp_cycle == 0) begin
            cycles++;
            mem_rd_valid = 1'b0;
            mem_wr_done  = 1'b0;
            if (rd_delay > 0) begin
                rd_delay--;
                if (rd_delay == 0) begin
                    mem_rd_valid = 1'b1;
                    mem_rdata    = mem_read(r.addr);
                end
            end
            if (wr_delay > 0) begin
                wr_delay--;
                if (wr_delay == 0) begin
                    mem_wr_done = 1'b1;
                end
            end
            if (mem_rd_req) begin
                rd_reqs++;
                check_equal("refill address", mem_addr, r.addr);
                rd_delay = 1 + next_rand() % 4;
            end
            if (mem_wr_req) begin
                wr_reqs++;
                check_equal("write address", mem_addr, r.addr);
                check_equal("write data", mem_wdata, r.wdata);
                check_equal("write strobe", mem_wstrb, r.wstrb);
                mem_words[r.addr] = merge_bytes(mem_read(r.addr), r.wdata, r.wstrb);
                wr_delay = 1 + next_rand() % 4;
            end
            if (resp_valid) begin
                resp_cycle = cycles;
                got        = rdata;
            end else begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        check_equal("response pulse width", resp_valid, 0);

        // compare with the prediction, then advance the model
        case (r.op)
            op_load: begin
                check_equal("load data", got, expected);
                check_equal("load write requests", wr_reqs, 0);
                if (way >= 0) begin
                    num_hits++;
                    check_equal("hit refill requests", rd_reqs, 0);
                    check_equal("hit response cycle", resp_cycle, 1);
                    check_equal("cached data", got, model_data[idx][way]);
                    model_lru[idx] = (way == 0);
                end else begin
                    num_misses++;
                    check_equal("miss refill requests", rd_reqs, 1);
                    way = choose_victim(idx);
                    if (model_valid[idx][way]) begin
                        num_evicts++;
                    end
                    model_tag[idx][way]   = tag;
                    model_valid[idx][way] = 1'b1;
                    model_data[idx][way]  = expected;
                    model_lru[idx]        = (way == 0);
                end
            end
            op_store: begin
                check_equal("store write requests", wr_reqs, 1);
                check_equal("store refill requests", rd_reqs, 0);
                // no allocate on a miss
                if (way >= 0) begin
                    model_data[idx][way] = merge_bytes(model_data[idx][way], r.wdata, r.wstrb);
                    model_lru[idx]       = (way == 0);
                end
            end
            default: begin
                check_equal("invalidate memory requests", rd_reqs + wr_reqs, 0);
                check_equal("invalidate response cycle", resp_cycle, 1);
                if (way >= 0) begin
                    model_valid[idx][way] = 1'b0;
                end
            end
        endcase
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        cache_req_t r;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        mem_rd_valid = 1'b0;
        mem_rdata    = '0;
        mem_wr_done  = 1'b0;
        // model starts empty, as the DUT after reset
        for (int s = 0; s < num_sets; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < num_ways; w++) begin
                model_tag[s][w]   = '0;
                model_valid[s][w] = 1'b0;
                model_data[s][w]  = '0;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_equal("busy after reset", busy, 0);
        check_equal("resp_valid after reset", resp_valid, 0);
        check_equal("mem_rd_req after reset", mem_rd_req, 0);
        check_equal("mem_wr_req after reset", mem_wr_req, 0);

        for (int n = 0; n < num_requests; n++) begin
            r = random_request();
            run_request(r);
        end
        @(negedge clk);
        $display("%0d requests, %0d load hits, %0d load misses, %0d evictions",
                 num_requests, num_hits, num_misses, num_evicts);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== filelist.f ====
source/dcache_pkg.sv
source/dual_port_ram.sv
source/dcache_tagv.sv
source/dcache_data.sv
source/dcache_lru.sv
source/dcache_ctrl.sv
source/dcache_top.sv
test/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/dual_port_ram.sv
  - source/dcache_tagv.sv
  - source/dcache_data.sv
  - source/dcache_lru.sv
  - source/dcache_ctrl.sv
  - source/dcache_top.sv
  - target: test
    files:
      - test/tb_dcache.sv
